// ==== hdl/soc_settings.svh ====
// Global widths, memory map and timing constants of the mini SoC.
// Include this header wherever one of the macros below is needed.
// Window lengths are in bytes, the SRAM depth in bus words.

`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Bus widths
`define SOC_DATA_WIDTH 32
`define SOC_ADDR_WIDTH 32

// --------------------------------------------------
// Memory map
// --------------------------------------------------
`define SOC_ROM_BASE     32'h0000_1000
`define SOC_ROM_LENGTH   32'h0000_0040
`define SOC_CLINT_BASE   32'h0200_0000
`define SOC_CLINT_LENGTH 32'h0000_0010
`define SOC_DRAM_BASE    32'h8000_0000

// DRAM window is this many words long
`define SOC_SRAM_WORDS 256

// Cycles after reset before a debug request may pass
`define SOC_DEBUG_DELAY_CYCLES 500

`endif

// ==== hdl/bus_pkg.sv ====
// Bus level types shared by the decoder, the targets and the testbench.
// Members are referenced by scoped name, e.g. bus_pkg::data_t.

`include "soc_settings.svh"

package bus_pkg;

  // One bus address
  typedef logic [`SOC_ADDR_WIDTH-1:0] addr_t;

  // One bus word
  typedef logic [`SOC_DATA_WIDTH-1:0] data_t;

  // --------------------------------------------------
  // 64-bit timer register
  // --------------------------------------------------
  typedef struct packed {
    data_t hi;
    data_t lo;
  } timer_halves_t;

  // Full view for the compare, half view for bus access
  typedef union packed {
    logic [2*`SOC_DATA_WIDTH-1:0] full;
    timer_halves_t                half;
  } timer_word_u;

endpackage

// ==== hdl/soc_map_pkg.sv ====
// Address map related types: which target a transfer goes to and
// the register layout inside the timer window.
// Members are referenced by scoped name, e.g. soc_map_pkg::TGT_ROM.

`include "soc_settings.svh"

package soc_map_pkg;

  // Decoded destination of a transfer
  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_SRAM,
    TGT_TIMER,
    TGT_NONE
  } target_e;

  // Word offsets inside the timer window
  typedef enum logic [$clog2(`SOC_CLINT_LENGTH / (`SOC_DATA_WIDTH / 8))-1:0] {
    MTIME_LO    = 0,
    MTIME_HI    = 1,
    MTIMECMP_LO = 2,
    MTIMECMP_HI = 3
  } timer_reg_e;

endpackage

// ==== hdl/mem_bus_if.sv ====
// Single-word request/acknowledge bus between the decoder and a target.
// Four-phase handshake: req up, ack up, req down, ack down.
// Address, we and wdata are held stable while req is high; rdata and
// err are valid while ack is high.

interface mem_bus_if;

  // Initiator side
  logic           req;
  logic           we;
  bus_pkg::addr_t addr;
  bus_pkg::data_t wdata;

  // Target side
  logic           ack;
  bus_pkg::data_t rdata;
  logic           err;

  modport initiator (
    output req, we, addr, wdata,
    input  ack, rdata, err
  );

  modport target (
    input  req, we, addr, wdata,
    output ack, rdata, err
  );

endinterface

// ==== hdl/addr_decoder.sv ====
// Address decoder between the top-level bus port and the three targets.
// Requests go combinationally to the target selected by the memory map;
// the selection is latched for the rest of the handshake. Addresses
// outside every window are acknowledged here with err high and rdata 0.

`include "soc_settings.svh"

module addr_decoder (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           req_i,
  input  logic           we_i,
  input  bus_pkg::addr_t addr_i,
  input  bus_pkg::data_t wdata_i,
  output logic           ack_o,
  output bus_pkg::data_t rdata_o,
  output logic           err_o,
  mem_bus_if.initiator   rom_bus,
  mem_bus_if.initiator   sram_bus,
  mem_bus_if.initiator   timer_bus
);

  localparam bus_pkg::addr_t DramLength = `SOC_SRAM_WORDS * (`SOC_DATA_WIDTH / 8);

  soc_map_pkg::target_e addr_tgt;
  soc_map_pkg::target_e cur_tgt;
  soc_map_pkg::target_e tgt_q;
  logic                 active_q;
  logic                 none_ack_q;

  function automatic logic in_window(bus_pkg::addr_t addr, bus_pkg::addr_t base,
                                     bus_pkg::addr_t len);
    return (addr >= base) && ((addr - base) < len);
  endfunction

  // --------------------------------------------------
  // Map lookup
  // --------------------------------------------------
  always_comb begin
    if (in_window(addr_i, `SOC_ROM_BASE, `SOC_ROM_LENGTH)) begin
      addr_tgt = soc_map_pkg::TGT_ROM;
    end else if (in_window(addr_i, `SOC_DRAM_BASE, DramLength)) begin
      addr_tgt = soc_map_pkg::TGT_SRAM;
    end else if (in_window(addr_i, `SOC_CLINT_BASE, `SOC_CLINT_LENGTH)) begin
      addr_tgt = soc_map_pkg::TGT_TIMER;
    end else begin
      addr_tgt = soc_map_pkg::TGT_NONE;
    end
  end

  // Keep the target until its ack has dropped
  assign cur_tgt = active_q ? tgt_q : addr_tgt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q   <= 1'b0;
      tgt_q      <= soc_map_pkg::TGT_NONE;
      none_ack_q <= 1'b0;
    end else begin
      active_q   <= req_i;
      none_ack_q <= req_i && (cur_tgt == soc_map_pkg::TGT_NONE);
      if (req_i && !active_q) begin
        tgt_q <= addr_tgt;
      end
    end
  end

  // Request fan-out
  assign rom_bus.req   = req_i && (cur_tgt == soc_map_pkg::TGT_ROM);
  assign sram_bus.req  = req_i && (cur_tgt == soc_map_pkg::TGT_SRAM);
  assign timer_bus.req = req_i && (cur_tgt == soc_map_pkg::TGT_TIMER);

  assign rom_bus.we      = we_i;
  assign rom_bus.addr    = addr_i;
  assign rom_bus.wdata   = wdata_i;
  assign sram_bus.we     = we_i;
  assign sram_bus.addr   = addr_i;
  assign sram_bus.wdata  = wdata_i;
  assign timer_bus.we    = we_i;
  assign timer_bus.addr  = addr_i;
  assign timer_bus.wdata = wdata_i;

  // Response return
  always_comb begin
    unique case (cur_tgt)
      soc_map_pkg::TGT_ROM: begin
        ack_o   = rom_bus.ack;
        rdata_o = rom_bus.rdata;
        err_o   = rom_bus.err;
      end
      soc_map_pkg::TGT_SRAM: begin
        ack_o   = sram_bus.ack;
        rdata_o = sram_bus.rdata;
        err_o   = sram_bus.err;
      end
      soc_map_pkg::TGT_TIMER: begin
        ack_o   = timer_bus.ack;
        rdata_o = timer_bus.rdata;
        err_o   = timer_bus.err;
      end
      default: begin
        ack_o   = none_ack_q;
        rdata_o = '0;
        err_o   = none_ack_q;
      end
    endcase
  end

  a_one_target_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({rom_bus.req, sram_bus.req, timer_bus.req}));

  // Every target must answer only an open request
  a_ack_after_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(ack_o) |-> $past(req_i));

endmodule

// ==== hdl/boot_rom.sv ====
// Boot ROM with sixteen fixed words behind the request/ack bus.
// Reads return the word at the address's word offset; writes are
// acknowledged with err high and leave the table unchanged.

module boot_rom (
  input logic       clk_i,
  input logic       rst_ni,
  mem_bus_if.target bus
);

  localparam int unsigned RomWords = 16;
  localparam int unsigned IdxWidth = $clog2(RomWords);
  localparam int unsigned ByteOff  = $clog2($bits(bus_pkg::data_t) / 8);

  // Small boot stub followed by constants
  localparam bus_pkg::data_t RomTable [RomWords] = '{
    32'h0000_0297, 32'h0202_8593, 32'hf140_2573, 32'h0182_b283,
    32'h0002_8067, 32'h0000_0000, 32'h8000_0000, 32'h0000_0000,
    32'h1357_9bdf, 32'h2468_ace0, 32'h0000_1000, 32'h0200_0000,
    32'h0000_0073, 32'h1050_0073, 32'hffff_ffff, 32'ha5a5_5a5a
  };

  logic           ack_q;
  logic           err_q;
  bus_pkg::data_t rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= bus.req;
      err_q <= bus.req && bus.we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      rdata_q <= RomTable[bus.addr[ByteOff +: IdxWidth]];
    end
  end

  assign bus.ack   = ack_q;
  assign bus.err   = err_q;
  assign bus.rdata = rdata_q;

endmodule

// ==== hdl/data_sram.sv ====
// Word-addressed data SRAM behind the request/ack bus.
// One word per transfer, no byte enables. The word index is the offset
// from the DRAM window base. Contents are cleared by reset.

`include "soc_settings.svh"

module data_sram (
  input logic       clk_i,
  input logic       rst_ni,
  mem_bus_if.target bus
);

  localparam int unsigned IdxWidth = $clog2(`SOC_SRAM_WORDS);
  localparam int unsigned ByteOff  = $clog2(`SOC_DATA_WIDTH / 8);

  bus_pkg::data_t   mem_q [`SOC_SRAM_WORDS];
  bus_pkg::addr_t   word_off;
  logic [IdxWidth-1:0] idx;
  logic             ack_q;
  bus_pkg::data_t   rdata_q;

  assign word_off = (bus.addr - `SOC_DRAM_BASE) >> ByteOff;
  assign idx      = word_off[IdxWidth-1:0];

  // --------------------------------------------------
  // Storage and handshake
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      for (int i = 0; i < `SOC_SRAM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      ack_q <= bus.req;
      // Store once, on the first cycle of the request
      if (bus.req && bus.we && !ack_q) begin
        mem_q[idx] <= bus.wdata;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      rdata_q <= mem_q[idx];
    end
  end

  assign bus.ack   = ack_q;
  assign bus.rdata = rdata_q;
  assign bus.err   = 1'b0;

  // Decoder only selects this target inside the DRAM window
  a_idx_in_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus.req |-> (word_off < `SOC_SRAM_WORDS));

endmodule

// ==== hdl/timer_clint.sv ====
// Core-local timer: 64-bit mtime stepped by the real-time clock, a
// 64-bit mtimecmp and a registered timer interrupt.
// mtime halves are read-only on the bus; mtimecmp halves are read/write.
// rtc_i is asynchronous to clk_i.

`include "soc_settings.svh"

module timer_clint (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      rtc_i,
  mem_bus_if.target bus,
  output logic      timer_irq_o
);

  localparam int unsigned RegWidth = $bits(soc_map_pkg::timer_reg_e);
  localparam int unsigned ByteOff  = $clog2(`SOC_DATA_WIDTH / 8);

  logic [1:0]              rtc_sync_q;
  logic                    rtc_prev_q;
  logic                    tick_q;
  bus_pkg::timer_word_u    mtime_q;
  bus_pkg::timer_word_u    mtimecmp_q;
  bus_pkg::addr_t          reg_off;
  soc_map_pkg::timer_reg_e reg_sel;
  logic                    wr_en;
  logic                    ack_q;
  logic                    err_q;
  logic                    irq_q;
  bus_pkg::data_t          rdata_q;

  assign reg_off = bus.addr - `SOC_CLINT_BASE;
  assign reg_sel = soc_map_pkg::timer_reg_e'(reg_off[ByteOff +: RegWidth]);
  assign wr_en   = bus.req && bus.we && !ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_sync_q      <= '0;
      rtc_prev_q      <= 1'b0;
      tick_q          <= 1'b0;
      mtime_q         <= '0;
      mtimecmp_q.full <= '1;
      ack_q           <= 1'b0;
      err_q           <= 1'b0;
      irq_q           <= 1'b0;
    end else begin
      // Two-flop synchronizer, then rising edge detect
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      tick_q     <= rtc_sync_q[1] && !rtc_prev_q;
      if (tick_q) begin
        mtime_q.full <= mtime_q.full + 1'b1;
      end

      ack_q <= bus.req;
      err_q <= bus.req && bus.we &&
               (reg_sel inside {soc_map_pkg::MTIME_LO, soc_map_pkg::MTIME_HI});
      if (wr_en) begin
        case (reg_sel)
          soc_map_pkg::MTIMECMP_LO: mtimecmp_q.half.lo <= bus.wdata;
          soc_map_pkg::MTIMECMP_HI: mtimecmp_q.half.hi <= bus.wdata;
          default: ;
        endcase
      end

      irq_q <= (mtime_q.full >= mtimecmp_q.full);
    end
  end

  // --------------------------------------------------
  // Read data
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      case (reg_sel)
        soc_map_pkg::MTIME_LO:    rdata_q <= mtime_q.half.lo;
        soc_map_pkg::MTIME_HI:    rdata_q <= mtime_q.half.hi;
        soc_map_pkg::MTIMECMP_LO: rdata_q <= mtimecmp_q.half.lo;
        default:                  rdata_q <= mtimecmp_q.half.hi;
      endcase
    end
  end

  assign bus.ack     = ack_q;
  assign bus.err     = err_q;
  assign bus.rdata   = rdata_q;
  assign timer_irq_o = irq_q;

  a_mtime_monotonic : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mtime_q.full >= $past(mtime_q.full));

endmodule

// ==== hdl/debug_gate.sv ====
// Debug request gate. A down-counter loaded at reset holds the request
// off for a fixed number of cycles so boot code can run first; after
// that the request passes only while debug is enabled.

`include "soc_settings.svh"

module debug_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_enable_i,
  output logic debug_req_o
);

  localparam int unsigned CntWidth = $clog2(`SOC_DEBUG_DELAY_CYCLES + 1);

  logic [CntWidth-1:0] cnt_q;

  // Stops at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntWidth'(`SOC_DEBUG_DELAY_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q == '0) && debug_enable_i && debug_req_i;

endmodule

// ==== hdl/mini_soc_top.sv ====
// Top level of the mini SoC fabric. One external bus master reaches
// the boot ROM, the data SRAM and the timer through the address decoder.
// Also carries the timer interrupt and the gated debug request.

module mini_soc_top (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           bus_req_i,
  input  logic           bus_we_i,
  input  bus_pkg::addr_t bus_addr_i,
  input  bus_pkg::data_t bus_wdata_i,
  output logic           bus_ack_o,
  output bus_pkg::data_t bus_rdata_o,
  output logic           bus_err_o,
  input  logic           rtc_i,
  input  logic           debug_req_i,
  input  logic           debug_enable_i,
  output logic           timer_irq_o,
  output logic           debug_req_o
);

  mem_bus_if rom_bus ();
  mem_bus_if sram_bus ();
  mem_bus_if timer_bus ();

  // --------------------------------------------------
  // Bus fabric
  // --------------------------------------------------
  addr_decoder addr_decoder_inst (
    .clk_i     ( clk_i       ),
    .rst_ni    ( rst_ni      ),
    .req_i     ( bus_req_i   ),
    .we_i      ( bus_we_i    ),
    .addr_i    ( bus_addr_i  ),
    .wdata_i   ( bus_wdata_i ),
    .ack_o     ( bus_ack_o   ),
    .rdata_o   ( bus_rdata_o ),
    .err_o     ( bus_err_o   ),
    .rom_bus   ( rom_bus     ),
    .sram_bus  ( sram_bus    ),
    .timer_bus ( timer_bus   )
  );

  boot_rom boot_rom_inst (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .bus    ( rom_bus )
  );

  data_sram data_sram_inst (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .bus    ( sram_bus )
  );

  timer_clint timer_clint_inst (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .bus         ( timer_bus   ),
    .timer_irq_o ( timer_irq_o )
  );

  // Debug request path
  debug_gate debug_gate_inst (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    )
  );

endmodule

// ==== verification/tb_mini_soc.sv ====
// Testbench for the mini SoC fabric.
// Replays the transfers and level checks of the stimulus file against the
// top level, prints one line per test and a closing summary.

`include "soc_settings.svh"

module tb_mini_soc;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned MaxLines    = 64;
  localparam int unsigned Cols        = 5;
  localparam int unsigned AckTimeout  = 100;
  localparam int unsigned WaitTimeout = 1000;
  localparam logic [31:0] OpRead      = 32'h0;
  localparam logic [31:0] OpWrite     = 32'h1;
  localparam logic [31:0] OpRtc       = 32'h2;
  localparam logic [31:0] OpDebug     = 32'h3;
  localparam logic [31:0] OpEnd       = 32'hf;

  logic           clk_i = 1'b0;
  logic           rst_ni;
  logic           bus_req_i;
  logic           bus_we_i;
  bus_pkg::addr_t bus_addr_i;
  bus_pkg::data_t bus_wdata_i;
  logic           bus_ack_o;
  bus_pkg::data_t bus_rdata_o;
  logic           bus_err_o;
  logic           rtc_i;
  logic           debug_req_i;
  logic           debug_enable_i;
  logic           timer_irq_o;
  logic           debug_req_o;

  logic [31:0] stim_mem [MaxLines*Cols];
  int          cycles_since_reset = 0;
  int          errors = 0;
  int          tests = 0;
  int          failed_tests = 0;

  mini_soc_top mini_soc_top_inst (.*);

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycles_since_reset <= cycles_since_reset + 1;
    end
  end

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_data(input string what, input bus_pkg::data_t got,
                            input bus_pkg::data_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s returned 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_err(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s gave err %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_target(input bus_pkg::addr_t addr, input soc_map_pkg::target_e got,
                              input soc_map_pkg::target_e exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: address 0x%08h routed to %s, expected region %s",
               $time, addr, got.name(), exp.name());
    end
  endtask

  // Memory map as seen from outside
  function automatic soc_map_pkg::target_e region_of(bus_pkg::addr_t addr);
    bus_pkg::addr_t dram_len;
    dram_len = `SOC_SRAM_WORDS * (`SOC_DATA_WIDTH / 8);
    if (addr >= `SOC_ROM_BASE && addr - `SOC_ROM_BASE < `SOC_ROM_LENGTH) begin
      return soc_map_pkg::TGT_ROM;
    end else if (addr >= `SOC_DRAM_BASE && addr - `SOC_DRAM_BASE < dram_len) begin
      return soc_map_pkg::TGT_SRAM;
    end else if (addr >= `SOC_CLINT_BASE && addr - `SOC_CLINT_BASE < `SOC_CLINT_LENGTH) begin
      return soc_map_pkg::TGT_TIMER;
    end
    return soc_map_pkg::TGT_NONE;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $finish;
  endtask

  // --------------------------------------------------
  // Stimulus tasks
  // --------------------------------------------------
  task automatic bus_transfer(input logic we, input bus_pkg::addr_t addr,
                              input bus_pkg::data_t wdata, output bus_pkg::data_t rdata,
                              output logic err, output soc_map_pkg::target_e tgt);
    int waited;
    waited = 0;
    @(posedge clk_i);
    bus_req_i   <= 1'b1;
    bus_we_i    <= we;
    bus_addr_i  <= addr;
    bus_wdata_i <= wdata;
    @(negedge clk_i);
    while (bus_ack_o !== 1'b1 && waited < AckTimeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (bus_ack_o !== 1'b1) begin
      abort_run($sformatf("Timeout: no acknowledge for address 0x%08h", addr));
    end
    rdata = bus_rdata_o;
    err   = bus_err_o;
    // Latched selection of the decoder
    tgt   = mini_soc_top_inst.addr_decoder_inst.cur_tgt;
    @(posedge clk_i);
    bus_req_i <= 1'b0;
    waited = 0;
    @(negedge clk_i);
    while (bus_ack_o !== 1'b0 && waited < AckTimeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (bus_ack_o !== 1'b0) begin
      abort_run($sformatf("Timeout: acknowledge stays high for address 0x%08h", addr));
    end
  endtask

  // Each pulse is 10 cycles high and 10 cycles low
  task automatic pulse_rtc(input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge clk_i);
      rtc_i <= 1'b1;
      repeat (10) @(posedge clk_i);
      rtc_i <= 1'b0;
      repeat (10) @(posedge clk_i);
    end
    @(negedge clk_i);
  endtask

  task automatic wait_cycle(input int target);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (cycles_since_reset < target && waited < WaitTimeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (cycles_since_reset < target) begin
      abort_run($sformatf("Timeout: cycle %0d after reset was never reached", target));
    end
  endtask

  initial begin
    bus_pkg::data_t       rdata;
    logic                 err;
    soc_map_pkg::target_e tgt;
    soc_map_pkg::target_e exp_tgt;
    logic [31:0]          op;
    logic [31:0]          addr;
    logic [31:0]          wdata;
    logic [31:0]          exp_data;
    logic [31:0]          exp_err;
    int                   errors_before;
    string                label;

    rst_ni         = 1'b0;
    bus_req_i      = 1'b0;
    bus_we_i       = 1'b0;
    bus_addr_i     = '0;
    bus_wdata_i    = '0;
    rtc_i          = 1'b0;
    debug_req_i    = 1'b1;
    debug_enable_i = 1'b1;
    $readmemh("verification/mini_soc_stimulus.txt", stim_mem);

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_level("bus_ack_o after reset", bus_ack_o, 1'b0);
    check_level("bus_err_o after reset", bus_err_o, 1'b0);
    check_level("timer_irq_o after reset", timer_irq_o, 1'b0);
    check_level("debug_req_o after reset", debug_req_o, 1'b0);
    tests++;
    failed_tests += (errors != 0);
    $display("test %0d reset: %s", tests, (errors == 0) ? "ok" : "FAIL");

    for (int idx = 0; idx < MaxLines; idx++) begin
      op       = stim_mem[idx*Cols];
      addr     = stim_mem[idx*Cols+1];
      wdata    = stim_mem[idx*Cols+2];
      exp_data = stim_mem[idx*Cols+3];
      exp_err  = stim_mem[idx*Cols+4];
      if (op === OpEnd) begin
        break;
      end
      if ($isunknown(op)) begin
        errors++;
        $display("Stimulus line %0d is missing or unreadable", idx);
        break;
      end
      errors_before = errors;
      case (op)
        OpRead, OpWrite: begin
          label = $sformatf("%s 0x%08h", (op == OpWrite) ? "write" : "read", addr);
          bus_transfer(op == OpWrite, addr, wdata, rdata, err, tgt);
          exp_tgt = region_of(addr);
          check_target(addr, tgt, exp_tgt);
          check_err(label, err, exp_err[0]);
          // Unmapped writes must still return zero data
          if (op == OpRead || exp_tgt == soc_map_pkg::TGT_NONE) begin
            check_data(label, rdata, exp_data);
          end
        end
        OpRtc: begin
          label = $sformatf("rtc %0d pulses", wdata);
          pulse_rtc(int'(wdata));
          check_level("timer_irq_o", timer_irq_o, exp_data[0]);
        end
        OpDebug: begin
          label = $sformatf("debug at cycle %0d", addr);
          wait_cycle(int'(addr));
          @(posedge clk_i);
          debug_enable_i <= wdata[0];
          @(negedge clk_i);
          check_level("debug_req_o", debug_req_o, exp_data[0]);
        end
        default: begin
          label = "unknown";
          errors++;
          $display("Stimulus line %0d has an unknown operation %0h", idx, op);
        end
      endcase
      tests++;
      failed_tests += (errors != errors_before);
      $display("test %0d %s: %s", tests, label, (errors == errors_before) ? "ok" : "FAIL");
    end

    $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== verification/mini_soc_stimulus.txt ====
// op addr wdata exp_data exp_err; op 0 read, 1 write, 2 rtc pulses (wdata = count,
// exp_data = timer irq), 3 debug (addr = cycle after reset, wdata = enable), f end
3 000001ea 00000001 00000000 0
3 000001f6 00000001 00000001 0
3 00000200 00000000 00000000 0
3 00000208 00000001 00000001 0
1 80000000 deadbeef 00000000 0
1 80000004 cafef00d 00000000 0
1 800003fc 0badc0de 00000000 0
1 80000010 12345678 00000000 0
1 80000004 87654321 00000000 0
0 800003fc 00000000 0badc0de 0
0 80000004 00000000 87654321 0
0 80000010 00000000 12345678 0
0 80000000 00000000 deadbeef 0
0 00001000 00000000 00000297 0
0 00001008 00000000 f1402573 0
0 00001020 00000000 13579bdf 0
0 0000103c 00000000 a5a55a5a 0
1 00001020 ffffffff 00000000 1
0 00001020 00000000 13579bdf 0
0 10012000 00000000 00000000 1
1 10012000 a5a5a5a5 00000000 1
1 02000008 00000005 00000000 0
1 0200000c 00000000 00000000 0
0 02000008 00000000 00000005 0
2 00000000 00000003 00000000 0
0 02000000 00000000 00000003 0
2 00000000 00000002 00000001 0
0 02000000 00000000 00000005 0
1 02000000 00000001 00000000 1
0 02000004 00000000 00000000 0
f 00000000 00000000 00000000 0

// ==== build.f ====
+incdir+hdl
hdl/bus_pkg.sv
hdl/soc_map_pkg.sv
hdl/mem_bus_if.sv
hdl/addr_decoder.sv
hdl/boot_rom.sv
hdl/data_sram.sv
hdl/timer_clint.sv
hdl/debug_gate.sv
hdl/mini_soc_top.sv
verification/tb_mini_soc.sv

// ==== Bender.yml ====
package:
  name: mini_soc

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/bus_pkg.sv
      - hdl/soc_map_pkg.sv
      - hdl/mem_bus_if.sv
      - hdl/addr_decoder.sv
      - hdl/boot_rom.sv
      - hdl/data_sram.sv
      - hdl/timer_clint.sv
      - hdl/debug_gate.sv
      - hdl/mini_soc_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verification/tb_mini_soc.sv
